//--- csr_file.f
csr_pkg.sv
csr_mode_except.sv
csr_timer.sv
csr_save_bank.sv
csr_read_mux.sv
csr_file.sv
csr_file_props.sv
csr_file_tb.sv

//--- csr_file.sv
`timescale 1ns/1ps

module csr_file #(
    parameter int N_SAVE = 4
) (
    input  logic                         clk,
    input  logic                         aresetn,
    input  logic                         csr_en,
    input  csr_pkg::csr_addr_t           addr,
    input  logic                         wen,
    input  csr_pkg::csr_word_t           wdata,
    input  logic                         exception,
    input  logic                         ertn,
    input  logic [6:0]                   expcode_in,
    input  logic                         wen_expcode,
    input  csr_pkg::csr_word_t           era_in,
    input  logic                         wen_era,
    input  csr_pkg::csr_word_t           badv_in,
    input  logic                         wen_badv,
    input  logic [csr_pkg::N_HW_IRQ-1:0] hardware_interrupt,
    output csr_pkg::csr_word_t           rdata,
    output csr_pkg::csr_word_t           crmd,
    output csr_pkg::csr_word_t           estat,
    output csr_pkg::csr_word_t           era_out,
    output csr_pkg::csr_word_t           eentry,
    output logic                         cpu_interrupt,
    output logic                         idle_over
);
    import csr_pkg::*;

    csr_word_t prmd;
    csr_word_t ecfg;
    csr_word_t badv;
    csr_word_t tcfg;
    csr_word_t tval;
    csr_word_t save_regs [N_SAVE];
    logic      ti_flag;

    csr_mode_except i_mode_except (
        .clk                (clk),
        .aresetn            (aresetn),
        .csr_en             (csr_en),
        .addr               (addr),
        .wen                (wen),
        .wdata              (wdata),
        .exception          (exception),
        .ertn               (ertn),
        .expcode_in         (expcode_in),
        .wen_expcode        (wen_expcode),
        .era_in             (era_in),
        .badv_in            (badv_in),
        .wen_era            (wen_era),
        .wen_badv           (wen_badv),
        .hardware_interrupt (hardware_interrupt),
        .ti_flag            (ti_flag),
        .crmd               (crmd),
        .prmd               (prmd),
        .ecfg               (ecfg),
        .estat              (estat),
        .era                (era_out),
        .badv               (badv),
        .eentry             (eentry),
        .cpu_interrupt      (cpu_interrupt),
        .idle_over          (idle_over)
    );

    csr_timer i_timer (
        .clk     (clk),
        .aresetn (aresetn),
        .csr_en  (csr_en),
        .addr    (addr),
        .wen     (wen),
        .wdata   (wdata),
        .tcfg    (tcfg),
        .tval    (tval),
        .ti_flag (ti_flag)
    );

    csr_save_bank #(
        .N_SAVE (N_SAVE)
    ) i_save_bank (
        .clk       (clk),
        .aresetn   (aresetn),
        .csr_en    (csr_en),
        .addr      (addr),
        .wen       (wen),
        .wdata     (wdata),
        .save_regs (save_regs)
    );

    csr_read_mux #(
        .N_SAVE (N_SAVE)
    ) i_read_mux (
        .addr      (addr),
        .crmd      (crmd),
        .prmd      (prmd),
        .ecfg      (ecfg),
        .estat     (estat),
        .era       (era_out),
        .badv      (badv),
        .eentry    (eentry),
        .tcfg      (tcfg),
        .tval      (tval),
        .save_regs (save_regs),
        .rdata     (rdata)
    );

endmodule

//--- csr_file_props.sv
`timescale 1ns/1ps

module csr_file_props (
    input logic               clk,
    input logic               aresetn,
    input logic               csr_en,
    input logic               wen,
    input csr_pkg::csr_addr_t addr,
    input csr_pkg::csr_word_t crmd,
    input csr_pkg::csr_word_t estat,
    input logic               cpu_interrupt,
    input logic               idle_over
);
    import csr_pkg::*;

    int unsigned err_count = 0;

    // No interrupt is taken with IE clear
    irq_needs_ie: assert property (@(posedge clk) disable iff (!aresetn)
        cpu_interrupt |-> crmd[CRMD_IE])
        else begin
            $error("cpu_interrupt high while CRMD.IE is low");
            err_count++;
        end

    pending_wakes: assert property (@(posedge clk) disable iff (!aresetn)
        (|estat[IRQ_BITS-1:0]) |-> idle_over)
        else begin
            $error("idle_over low while an interrupt is pending");
            err_count++;
        end

    // Clear takes effect at the write edge
    ticlr_clears: assert property (@(posedge clk) disable iff (!aresetn)
        (csr_en && wen && addr == CSR_TICLR) |=> !estat[ESTAT_IS_TI])
        else begin
            $error("timer interrupt still set after a TICLR write");
            err_count++;
        end

endmodule

bind csr_file csr_file_props i_props (
    .clk           (clk),
    .aresetn       (aresetn),
    .csr_en        (csr_en),
    .wen           (wen),
    .addr          (addr),
    .crmd          (crmd),
    .estat         (estat),
    .cpu_interrupt (cpu_interrupt),
    .idle_over     (idle_over)
);

//--- csr_file_tb.sv
`timescale 1ns/1ps

module csr_file_tb;
    import csr_pkg::*;

    localparam int N_SAVE = 4;

    logic                clk;
    logic                aresetn;
    logic                csr_en;
    csr_addr_t           addr;
    logic                wen;
    csr_word_t           wdata;
    logic                exception;
    logic                ertn;
    logic [6:0]          expcode_in;
    logic                wen_expcode;
    csr_word_t           era_in;
    logic                wen_era;
    csr_word_t           badv_in;
    logic                wen_badv;
    logic [N_HW_IRQ-1:0] hardware_interrupt;
    csr_word_t           rdata;
    csr_word_t           crmd;
    csr_word_t           estat;
    csr_word_t           era_out;
    csr_word_t           eentry;
    logic                cpu_interrupt;
    logic                idle_over;

    logic [15:0] lfsr;
    csr_word_t   save_exp [N_SAVE];
    csr_word_t   word_a;
    csr_word_t   word_b;
    int          cycles;

    csr_file #(
        .N_SAVE (N_SAVE)
    ) i_dut (
        .clk                (clk),
        .aresetn            (aresetn),
        .csr_en             (csr_en),
        .addr               (addr),
        .wen                (wen),
        .wdata              (wdata),
        .exception          (exception),
        .ertn               (ertn),
        .expcode_in         (expcode_in),
        .wen_expcode        (wen_expcode),
        .era_in             (era_in),
        .wen_era            (wen_era),
        .badv_in            (badv_in),
        .wen_badv           (wen_badv),
        .hardware_interrupt (hardware_interrupt),
        .rdata              (rdata),
        .crmd               (crmd),
        .estat              (estat),
        .era_out            (era_out),
        .eentry             (eentry),
        .cpu_interrupt      (cpu_interrupt),
        .idle_over          (idle_over)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic csr_word_t crmd_word(input logic [1:0] plv, input logic ie,
                                            input logic da, input logic pg);
        csr_word_t w;
        w = '0;
        w[CRMD_PLV_HI:CRMD_PLV_LO] = plv;
        w[CRMD_IE] = ie;
        w[CRMD_DA] = da;
        w[CRMD_PG] = pg;
        return w;
    endfunction

    task automatic rand_word(output csr_word_t w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[30:0], lfsr[0]};
        end
    endtask

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input csr_word_t got, input csr_word_t exp);
        assert (got === exp)
            else fail_now($sformatf("Mismatch %s expected %h got %h", name, exp, got));
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic sw_write(input csr_addr_t a, input csr_word_t d);
        csr_en = 1'b1;
        wen    = 1'b1;
        addr   = a;
        wdata  = d;
        tick();
        csr_en = 1'b0;
        wen    = 1'b0;
    endtask

    task automatic read_reg(input string name, input csr_addr_t a, input csr_word_t exp);
        addr = a;
        #1;
        check_word(name, rdata, exp);
    endtask

    initial begin
        lfsr               = 16'd8789;
        aresetn            = 1'b0;
        csr_en             = 1'b0;
        addr               = '0;
        wen                = 1'b0;
        wdata              = '0;
        exception          = 1'b0;
        ertn               = 1'b0;
        expcode_in         = '0;
        wen_expcode        = 1'b0;
        era_in             = '0;
        wen_era            = 1'b0;
        badv_in            = '0;
        wen_badv           = 1'b0;
        hardware_interrupt = '0;
        repeat (2) @(posedge clk);
        #1;
        aresetn = 1'b1;

        read_reg("crmd", CSR_CRMD, CRMD_RESET);
        read_reg("prmd", CSR_PRMD, 32'h0);
        read_reg("estat", CSR_ESTAT, 32'h0);
        read_reg("era", CSR_ERA, 32'h0);
        read_reg("save0", CSR_SAVE0, 32'h0);
        read_reg("tval", CSR_TVAL, 32'h0);
        check_word("cpu_interrupt", 32'(cpu_interrupt), 32'h0);
        check_word("idle_over", 32'(idle_over), 32'h0);

        for (int i = 0; i < N_SAVE; i++) begin
            rand_word(save_exp[i]);
            sw_write(CSR_SAVE0 + csr_addr_t'(i), save_exp[i]);
        end
        for (int i = 0; i < N_SAVE; i++) begin
            read_reg($sformatf("save%0d", i), CSR_SAVE0 + csr_addr_t'(i), save_exp[i]);
        end
        // Write strobe without csr_en
        wen   = 1'b1;
        addr  = CSR_SAVE0;
        wdata = ~save_exp[0];
        tick();
        wen = 1'b0;
        read_reg("save0", CSR_SAVE0, save_exp[0]);

        sw_write(CSR_CRMD, crmd_word(2'd2, 1'b1, 1'b0, 1'b0));
        read_reg("crmd", CSR_CRMD, crmd_word(2'd2, 1'b1, 1'b1, 1'b0));
        sw_write(CSR_CRMD, crmd_word(2'd1, 1'b0, 1'b1, 1'b1));
        read_reg("crmd", CSR_CRMD, crmd_word(2'd1, 1'b0, 1'b1, 1'b0));
        sw_write(CSR_CRMD, crmd_word(2'd3, 1'b1, 1'b0, 1'b1));
        read_reg("crmd", CSR_CRMD, crmd_word(2'd3, 1'b1, 1'b0, 1'b1));

        // Entry address keeps only VA
        rand_word(word_a);
        sw_write(CSR_EENTRY, word_a);
        read_reg("eentry", CSR_EENTRY, word_a & 32'hFFFF_FFC0);
        check_word("eentry", eentry, word_a & 32'hFFFF_FFC0);

        rand_word(word_a);
        rand_word(word_b);
        exception   = 1'b1;
        wen_expcode = 1'b1;
        expcode_in  = 7'h4A;
        wen_era     = 1'b1;
        era_in      = word_a;
        wen_badv    = 1'b1;
        badv_in     = word_b;
        tick();
        exception   = 1'b0;
        wen_expcode = 1'b0;
        wen_era     = 1'b0;
        wen_badv    = 1'b0;
        read_reg("prmd", CSR_PRMD, 32'h7);
        read_reg("crmd", CSR_CRMD, crmd_word(2'd0, 1'b0, 1'b0, 1'b1));
        check_word("crmd", crmd, crmd_word(2'd0, 1'b0, 1'b0, 1'b1));
        read_reg("era", CSR_ERA, word_a);
        check_word("era_out", era_out, word_a);
        read_reg("badv", CSR_BADV, word_b);
        read_reg("estat", CSR_ESTAT, (32'h0A << ESTAT_ECODE_LO) | (32'h1 << ESTAT_ESUBCODE_LO));
        ertn = 1'b1;
        tick();
        ertn = 1'b0;
        read_reg("crmd", CSR_CRMD, crmd_word(2'd3, 1'b1, 1'b0, 1'b1));
        // Sub-code is dropped when the code is zero
        wen_expcode = 1'b1;
        expcode_in  = 7'h40;
        tick();
        wen_expcode = 1'b0;
        read_reg("estat", CSR_ESTAT, 32'h0);

        sw_write(CSR_ESTAT, 32'h1);
        check_word("idle_over", 32'(idle_over), 32'h1);
        check_word("cpu_interrupt", 32'(cpu_interrupt), 32'h0);
        sw_write(CSR_ECFG, 32'h1FFF);
        read_reg("ecfg", CSR_ECFG, 32'h1BFF);
        sw_write(CSR_ECFG, 32'h1);
        check_word("cpu_interrupt", 32'(cpu_interrupt), 32'h1);
        sw_write(CSR_ESTAT, 32'h0);
        check_word("idle_over", 32'(idle_over), 32'h0);
        hardware_interrupt[3] = 1'b1;
        #1;
        check_word("idle_over", 32'(idle_over), 32'h1);
        check_word("cpu_interrupt", 32'(cpu_interrupt), 32'h0);
        sw_write(CSR_ECFG, 32'h1 << (ESTAT_IS_HARD_LO + 3));
        check_word("cpu_interrupt", 32'(cpu_interrupt), 32'h1);
        hardware_interrupt = '0;
        sw_write(CSR_ECFG, 32'h0);
        check_word("cpu_interrupt", 32'(cpu_interrupt), 32'h0);

        sw_write(CSR_TCFG, (32'd3 << TCFG_INITVAL_LO) | 32'h1);
        cycles = 0;
        while (!estat[ESTAT_IS_TI] && cycles < 3 * 4 + 10) begin
            tick();
            cycles++;
        end
        if (!estat[ESTAT_IS_TI]) begin
            fail_now("Timer interrupt did not arrive within the timeout");
        end
        check_word("estat", estat, 32'h1 << ESTAT_IS_TI);
        read_reg("tval", CSR_TVAL, 32'h0);
        read_reg("tcfg", CSR_TCFG, 32'hD);
        check_word("idle_over", 32'(idle_over), 32'h1);
        sw_write(CSR_TICLR, 32'h1);
        read_reg("estat", CSR_ESTAT, 32'h0);
        tick();

        if (i_dut.i_props.err_count != 0) begin
            fail_now("Bound assertions reported failures");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- csr_mode_except.sv
`timescale 1ns/1ps

module csr_mode_except (
    input  logic                         clk,
    input  logic                         aresetn,
    input  logic                         csr_en,
    input  csr_pkg::csr_addr_t           addr,
    input  logic                         wen,
    input  csr_pkg::csr_word_t           wdata,
    input  logic                         exception,
    input  logic                         ertn,
    input  logic [6:0]                   expcode_in,
    input  logic                         wen_expcode,
    input  csr_pkg::csr_word_t           era_in,
    input  csr_pkg::csr_word_t           badv_in,
    input  logic                         wen_era,
    input  logic                         wen_badv,
    input  logic [csr_pkg::N_HW_IRQ-1:0] hardware_interrupt,
    input  logic                         ti_flag,
    output csr_pkg::csr_word_t           crmd,
    output csr_pkg::csr_word_t           prmd,
    output csr_pkg::csr_word_t           ecfg,
    output csr_pkg::csr_word_t           estat,
    output csr_pkg::csr_word_t           era,
    output csr_pkg::csr_word_t           badv,
    output csr_pkg::csr_word_t           eentry,
    output logic                         cpu_interrupt,
    output logic                         idle_over
);
    import csr_pkg::*;

    logic                                    sw_wr;
    logic [CRMD_PLV_HI:CRMD_PLV_LO]          crmd_plv;
    logic                                    crmd_ie;
    logic                                    crmd_da;
    logic                                    crmd_pg;
    logic [CRMD_DATF_HI:CRMD_DATF_LO]        crmd_datf;
    logic [CRMD_DATM_HI:CRMD_DATM_LO]        crmd_datm;
    logic [PRMD_PPLV_HI:PRMD_PPLV_LO]        prmd_pplv;
    logic                                    prmd_pie;
    logic [IRQ_BITS-1:0]                     ecfg_lie;
    logic [ESTAT_IS_SOFT_HI:ESTAT_IS_SOFT_LO] estat_is_soft;
    ecode_t                                  estat_ecode;
    logic [ESTAT_ESUBCODE_HI:ESTAT_ESUBCODE_LO] estat_esubcode;
    logic [EENTRY_VA_HI:EENTRY_VA_LO]        eentry_va;

    assign sw_wr = csr_en & wen;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd_plv  <= CRMD_RESET[CRMD_PLV_HI:CRMD_PLV_LO];
            crmd_ie   <= CRMD_RESET[CRMD_IE];
            crmd_da   <= CRMD_RESET[CRMD_DA];
            crmd_pg   <= CRMD_RESET[CRMD_PG];
            crmd_datf <= CRMD_RESET[CRMD_DATF_HI:CRMD_DATF_LO];
            crmd_datm <= CRMD_RESET[CRMD_DATM_HI:CRMD_DATM_LO];
        end else if (ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (exception) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (sw_wr && addr == CSR_CRMD) begin
            crmd_plv  <= wdata[CRMD_PLV_HI:CRMD_PLV_LO];
            crmd_ie   <= wdata[CRMD_IE];
            crmd_datf <= wdata[CRMD_DATF_HI:CRMD_DATF_LO];
            crmd_datm <= wdata[CRMD_DATM_HI:CRMD_DATM_LO];
            // Only a legal PG/DA pair is taken
            if (wdata[CRMD_PG] ^ wdata[CRMD_DA]) begin
                crmd_pg <= wdata[CRMD_PG];
                crmd_da <= wdata[CRMD_DA];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (exception) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (sw_wr && addr == CSR_PRMD) begin
            prmd_pplv <= wdata[PRMD_PPLV_HI:PRMD_PPLV_LO];
            prmd_pie  <= wdata[PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ecfg_lie      <= '0;
            eentry_va     <= '0;
            estat_is_soft <= '0;
        end else if (sw_wr) begin
            if (addr == CSR_ECFG) begin
                ecfg_lie <= wdata[IRQ_BITS-1:0] & ECFG_LIE_MASK;
            end
            if (addr == CSR_EENTRY) begin
                eentry_va <= wdata[EENTRY_VA_HI:EENTRY_VA_LO];
            end
            if (addr == CSR_ESTAT && !wen_expcode) begin
                estat_is_soft <= wdata[ESTAT_IS_SOFT_HI:ESTAT_IS_SOFT_LO];
            end
        end
    end

    // Sub-code is only meaningful alongside a nonzero code
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else if (wen_expcode) begin
            estat_ecode    <= expcode_in[5:0];
            estat_esubcode <= (expcode_in[5:0] == '0) ? '0 : {8'b0, expcode_in[6]};
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            era  <= '0;
            badv <= '0;
        end else begin
            if (wen_era) begin
                era <= era_in;
            end else if (sw_wr && addr == CSR_ERA) begin
                era <= wdata;
            end
            if (wen_badv) begin
                badv <= badv_in;
            end else if (sw_wr && addr == CSR_BADV) begin
                badv <= wdata;
            end
        end
    end

    always_comb begin
        crmd = '0;
        crmd[CRMD_PLV_HI:CRMD_PLV_LO]   = crmd_plv;
        crmd[CRMD_IE]                   = crmd_ie;
        crmd[CRMD_DA]                   = crmd_da;
        crmd[CRMD_PG]                   = crmd_pg;
        crmd[CRMD_DATF_HI:CRMD_DATF_LO] = crmd_datf;
        crmd[CRMD_DATM_HI:CRMD_DATM_LO] = crmd_datm;
        prmd = '0;
        prmd[PRMD_PPLV_HI:PRMD_PPLV_LO] = prmd_pplv;
        prmd[PRMD_PIE]                  = prmd_pie;
        ecfg = '0;
        ecfg[IRQ_BITS-1:0] = ecfg_lie;
        eentry = '0;
        eentry[EENTRY_VA_HI:EENTRY_VA_LO] = eentry_va;
    end

    // Hardware and timer bits follow their sources directly
    always_comb begin
        estat = '0;
        estat[ESTAT_IS_SOFT_HI:ESTAT_IS_SOFT_LO]   = estat_is_soft;
        estat[ESTAT_IS_HARD_HI:ESTAT_IS_HARD_LO]   = hardware_interrupt;
        estat[ESTAT_IS_TI]                         = ti_flag;
        estat[ESTAT_ECODE_HI:ESTAT_ECODE_LO]       = estat_ecode;
        estat[ESTAT_ESUBCODE_HI:ESTAT_ESUBCODE_LO] = estat_esubcode;
    end

    assign cpu_interrupt = crmd_ie & (|(ecfg_lie & estat[IRQ_BITS-1:0]));
    // Any pending source ends idle, enabled or not
    assign idle_over = |estat[IRQ_BITS-1:0];

endmodule

//--- csr_pkg.sv
package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_word_t;
    typedef logic [5:0]  ecode_t;

    // Register addresses
    localparam csr_addr_t CSR_CRMD   = 14'h0;
    localparam csr_addr_t CSR_PRMD   = 14'h1;
    localparam csr_addr_t CSR_ECFG   = 14'h4;
    localparam csr_addr_t CSR_ESTAT  = 14'h5;
    localparam csr_addr_t CSR_ERA    = 14'h6;
    localparam csr_addr_t CSR_BADV   = 14'h7;
    localparam csr_addr_t CSR_EENTRY = 14'hC;
    localparam csr_addr_t CSR_SAVE0  = 14'h30;
    localparam csr_addr_t CSR_TCFG   = 14'h41;
    localparam csr_addr_t CSR_TVAL   = 14'h42;
    localparam csr_addr_t CSR_TICLR  = 14'h44;

    // CRMD fields
    localparam int CRMD_PLV_LO  = 0;
    localparam int CRMD_PLV_HI  = 1;
    localparam int CRMD_IE      = 2;
    localparam int CRMD_DA      = 3;
    localparam int CRMD_PG      = 4;
    localparam int CRMD_DATF_LO = 5;
    localparam int CRMD_DATF_HI = 6;
    localparam int CRMD_DATM_LO = 7;
    localparam int CRMD_DATM_HI = 8;

    localparam int PRMD_PPLV_LO = 0;
    localparam int PRMD_PPLV_HI = 1;
    localparam int PRMD_PIE     = 2;

    localparam int IRQ_BITS = 13;
    localparam int N_HW_IRQ = 8;
    // Bit 10 of LIE is reserved
    localparam logic [IRQ_BITS-1:0] ECFG_LIE_MASK = 13'h1BFF;

    localparam int ESTAT_IS_SOFT_LO  = 0;
    localparam int ESTAT_IS_SOFT_HI  = 1;
    localparam int ESTAT_IS_HARD_LO  = 2;
    localparam int ESTAT_IS_HARD_HI  = 9;
    localparam int ESTAT_IS_TI       = 11;
    localparam int ESTAT_ECODE_LO    = 16;
    localparam int ESTAT_ECODE_HI    = 21;
    localparam int ESTAT_ESUBCODE_LO = 22;
    localparam int ESTAT_ESUBCODE_HI = 30;

    localparam int EENTRY_VA_LO = 6;
    localparam int EENTRY_VA_HI = 31;

    localparam int TCFG_EN         = 0;
    localparam int TCFG_PERIODIC   = 1;
    localparam int TCFG_INITVAL_LO = 2;
    localparam int TCFG_INITVAL_HI = 31;

    // Direct address mode out of reset
    localparam csr_word_t CRMD_RESET = 32'h8;

endpackage

//--- csr_read_mux.sv
`timescale 1ns/1ps

module csr_read_mux #(
    parameter int N_SAVE = 4
) (
    input  csr_pkg::csr_addr_t addr,
    input  csr_pkg::csr_word_t crmd,
    input  csr_pkg::csr_word_t prmd,
    input  csr_pkg::csr_word_t ecfg,
    input  csr_pkg::csr_word_t estat,
    input  csr_pkg::csr_word_t era,
    input  csr_pkg::csr_word_t badv,
    input  csr_pkg::csr_word_t eentry,
    input  csr_pkg::csr_word_t tcfg,
    input  csr_pkg::csr_word_t tval,
    input  csr_pkg::csr_word_t save_regs [N_SAVE],
    output csr_pkg::csr_word_t rdata
);
    import csr_pkg::*;

    // TICLR and unmapped addresses fall through as zero
    always_comb begin
        rdata = '0;
        case (addr)
            CSR_CRMD:   rdata = crmd;
            CSR_PRMD:   rdata = prmd;
            CSR_ECFG:   rdata = ecfg;
            CSR_ESTAT:  rdata = estat;
            CSR_ERA:    rdata = era;
            CSR_BADV:   rdata = badv;
            CSR_EENTRY: rdata = eentry;
            CSR_TCFG:   rdata = tcfg;
            CSR_TVAL:   rdata = tval;
            default: begin
                for (int i = 0; i < N_SAVE; i++) begin
                    if (addr == CSR_SAVE0 + csr_addr_t'(i)) begin
                        rdata = save_regs[i];
                    end
                end
            end
        endcase
    end

endmodule

//--- csr_save_bank.sv
`timescale 1ns/1ps

module csr_save_bank #(
    parameter int N_SAVE = 4
) (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               csr_en,
    input  csr_pkg::csr_addr_t addr,
    input  logic               wen,
    input  csr_pkg::csr_word_t wdata,
    output csr_pkg::csr_word_t save_regs [N_SAVE]
);
    import csr_pkg::*;

    logic sw_wr;

    assign sw_wr = csr_en & wen;

    // SAVEn sits at CSR_SAVE0 + n
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            for (int i = 0; i < N_SAVE; i++) begin
                save_regs[i] <= '0;
            end
        end else if (sw_wr) begin
            for (int i = 0; i < N_SAVE; i++) begin
                if (addr == CSR_SAVE0 + csr_addr_t'(i)) begin
                    save_regs[i] <= wdata;
                end
            end
        end
    end

endmodule

//--- csr_timer.sv
`timescale 1ns/1ps

module csr_timer (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               csr_en,
    input  csr_pkg::csr_addr_t addr,
    input  logic               wen,
    input  csr_pkg::csr_word_t wdata,
    output csr_pkg::csr_word_t tcfg,
    output csr_pkg::csr_word_t tval,
    output logic               ti_flag
);
    import csr_pkg::*;

    logic                                  sw_wr;
    logic                                  tcfg_en;
    logic                                  tcfg_periodic;
    logic [TCFG_INITVAL_HI:TCFG_INITVAL_LO] tcfg_initval;
    logic                                  reload_pulse;
    logic                                  time_out;

    assign sw_wr = csr_en & wen;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
            reload_pulse  <= 1'b0;
        end else begin
            reload_pulse <= sw_wr && addr == CSR_TCFG;
            if (sw_wr && addr == CSR_TCFG) begin
                tcfg_en       <= wdata[TCFG_EN];
                tcfg_periodic <= wdata[TCFG_PERIODIC];
                tcfg_initval  <= wdata[TCFG_INITVAL_HI:TCFG_INITVAL_LO];
            end
        end
    end

    // Reload value is one above INITVAL*4 so that zero still fires
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval     <= '0;
            time_out <= 1'b0;
        end else if (reload_pulse || tval == '0) begin
            time_out <= 1'b0;
            if (reload_pulse || tcfg_periodic) begin
                tval <= {tcfg_initval, 2'b01};
            end
        end else if (tcfg_en) begin
            tval     <= tval - 1'b1;
            time_out <= (tval == 32'd1);
        end
    end

    // Sticky until software clears it through TICLR
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ti_flag <= 1'b0;
        end else if (sw_wr && addr == CSR_TICLR) begin
            ti_flag <= 1'b0;
        end else if (time_out) begin
            ti_flag <= 1'b1;
        end
    end

    always_comb begin
        tcfg = '0;
        tcfg[TCFG_EN]                          = tcfg_en;
        tcfg[TCFG_PERIODIC]                    = tcfg_periodic;
        tcfg[TCFG_INITVAL_HI:TCFG_INITVAL_LO]  = tcfg_initval;
    end

endmodule
